// File: compile.f
verilog/uma_timing_pkg.sv
verilog/uma_mem_pkg.sv
verilog/uma_slot_timer.sv
verilog/uma_client_port.sv
verilog/uma_primary_mux.sv
verilog/uma_top.sv
tb/uma_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of the arbiter testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module uma_tb -Mdir obj_dir -o uma_sim -f compile.f \
    && ./obj_dir/uma_sim | tee /dev/stderr | grep -q "No errors" \
    && exit 0 || exit 1

// File: tb/uma_golden.txt
# name channel op addr wdata base exp_pri_addr exp_rdata (hex values)
# op is idle, wr, rd or rf; a trailing + starts the line together with the next one
reset_idle 0 idle 000014 0000 000000 000000 0000
main_wr    0 wr   000100 1234 001000 001100 0000
main_rd    0 rd   000100 0000 001000 001100 1234
main_wr2   0 wr   abcdef 5a5a 100000 bbcdef 0000
main_rd2   0 rd   abcdef 0000 100000 bbcdef 5a5a
video_wr   1 wr   000020 c3c3 fffff0 000010 0000
video_rd   1 rd   000020 0000 fffff0 000010 c3c3
video_wr2  1 wr   ffffff 0f0f 000002 000001 0000
video_rd2  1 rd   ffffff 0000 000002 000001 0f0f
main_rf    0 rf   000123 0000 001000 000000 0000
video_rf   1 rf   000456 0000 fffff0 000000 0000
dual_wr_m  0 wr+  000200 1111 000000 000200 0000
dual_wr_v  1 wr   000200 2222 000008 000208 0000
dual_rd_m  0 rd+  000200 0000 000000 000200 1111
dual_rd_v  1 rd   000200 0000 000008 000208 2222

// File: tb/uma_tb.sv
// Testbench for the unified memory arbiter
// Clock and CLK_EN generation, shared RAM model, client drivers,
// checks against the golden stimulus file

`default_nettype none

module uma_tb;

    localparam int TIMEOUT   = 200;     // Cycles per wait loop
    localparam int MAX_TESTS = 32;
    localparam int LOG_DEPTH = 64;
    localparam int OP_RD     = 0;
    localparam int OP_WR     = 1;
    localparam int OP_RF     = 2;
    localparam int OP_IDLE   = 3;

    logic               CLK = 1'b0;
    logic               RESET_n;
    logic               CLK_EN;
    uma_mem_pkg::addr_t base_0;
    uma_mem_pkg::addr_t base_1;
    uma_mem_pkg::addr_t main_addr;
    uma_mem_pkg::data_t main_din;
    logic               main_oe_n;
    logic               main_we_n;
    logic               main_rfsh_n;
    uma_mem_pkg::data_t main_dout;
    logic               main_ack_n;
    uma_mem_pkg::addr_t video_addr;
    uma_mem_pkg::data_t video_din;
    logic               video_oe_n;
    logic               video_we_n;
    logic               video_rfsh_n;
    uma_mem_pkg::data_t video_dout;
    logic               video_ack_n;
    uma_mem_pkg::addr_t pri_addr;
    uma_mem_pkg::data_t pri_din;
    logic               pri_oe_n;
    logic               pri_we_n;
    logic               pri_rfsh_n;
    logic               pri_ack_n;
    uma_mem_pkg::data_t pri_dout;

    // Shared RAM model state and its access log
    uma_mem_pkg::data_t mem [64];
    int                 ram_wait;
    int                 log_count;
    int                 onehot_bad;
    int                 log_op   [LOG_DEPTH];
    uma_mem_pkg::addr_t log_addr [LOG_DEPTH];
    uma_mem_pkg::data_t log_din  [LOG_DEPTH];

    // Golden stimulus
    string              t_name     [MAX_TESTS];
    string              t_op       [MAX_TESTS];
    int                 t_ch       [MAX_TESTS];
    uma_mem_pkg::addr_t t_addr     [MAX_TESTS];
    uma_mem_pkg::data_t t_wdata    [MAX_TESTS];
    uma_mem_pkg::addr_t t_base     [MAX_TESTS];
    uma_mem_pkg::addr_t t_exp_addr [MAX_TESTS];
    uma_mem_pkg::data_t t_exp_data [MAX_TESTS];
    int                 n_tests;
    int                 errors;
    bit                 aborted;

    uma_top uut (
        .CLK          (CLK),
        .RESET_n      (RESET_n),
        .CLK_EN       (CLK_EN),
        .base_0       (base_0),
        .base_1       (base_1),
        .main_addr    (main_addr),
        .main_din     (main_din),
        .main_oe_n    (main_oe_n),
        .main_we_n    (main_we_n),
        .main_rfsh_n  (main_rfsh_n),
        .main_dout    (main_dout),
        .main_ack_n   (main_ack_n),
        .video_addr   (video_addr),
        .video_din    (video_din),
        .video_oe_n   (video_oe_n),
        .video_we_n   (video_we_n),
        .video_rfsh_n (video_rfsh_n),
        .video_dout   (video_dout),
        .video_ack_n  (video_ack_n),
        .pri_addr     (pri_addr),
        .pri_din      (pri_din),
        .pri_oe_n     (pri_oe_n),
        .pri_we_n     (pri_we_n),
        .pri_rfsh_n   (pri_rfsh_n),
        .pri_ack_n    (pri_ack_n),
        .pri_dout     (pri_dout)
    );

    always #2 CLK = ~CLK;

    // 3.58 MHz enable, one pulse per SLOT_DIV clocks
    initial begin
        int en_cnt;
        CLK_EN = 1'b0;
        en_cnt = 0;
        forever begin
            @(posedge CLK);
            #1;
            if (!RESET_n) begin
                en_cnt = 0;
                CLK_EN = 1'b0;
            end else begin
                CLK_EN = (en_cnt == uma_timing_pkg::SLOT_DIV - 1);
                en_cnt = CLK_EN ? 0 : en_cnt + 1;
            end
        end
    end

    // Shared RAM, answers two cycles after a strobe falls
    initial begin
        pri_ack_n  = 1'b1;
        pri_dout   = '0;
        ram_wait   = 0;
        log_count  = 0;
        onehot_bad = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 16'hc000 | 16'(i * 257);
        end
        forever begin
            @(posedge CLK);
            #1;
            if (!pri_ack_n) begin
                pri_ack_n = 1'b1;       // Strobes went high on this edge
                ram_wait  = 0;
            end else if (!pri_oe_n || !pri_we_n || !pri_rfsh_n) begin
                ram_wait = ram_wait + 1;
                if (ram_wait == 1 && log_count < LOG_DEPTH) begin
                    if ($countones({pri_oe_n, pri_we_n, pri_rfsh_n}) < 2) begin
                        $display("Shared RAM strobes are not one-hot at time %0t", $time);
                        onehot_bad = onehot_bad + 1;
                    end
                    log_op[log_count]   = !pri_we_n ? OP_WR : (!pri_rfsh_n ? OP_RF : OP_RD);
                    log_addr[log_count] = pri_addr;
                    log_din[log_count]  = pri_din;
                    log_count           = log_count + 1;
                end
                if (ram_wait == 2) begin
                    if (!pri_we_n) begin
                        mem[pri_addr[5:0]] = pri_din;
                    end
                    pri_dout  = mem[pri_addr[5:0]];
                    pri_ack_n = 1'b0;
                end
            end else begin
                ram_wait = 0;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    function automatic int op_code(input string op);
        string head;
        head = op.substr(0, 1);
        if (head == "wr") begin
            return OP_WR;
        end else if (head == "rf") begin
            return OP_RF;
        end else if (head == "id") begin
            return OP_IDLE;
        end
        return OP_RD;
    endfunction

    function automatic logic ack_of(input int ch);
        return (ch == uma_mem_pkg::CH_MAIN) ? main_ack_n : video_ack_n;
    endfunction

    function automatic uma_mem_pkg::data_t dout_of(input int ch);
        return (ch == uma_mem_pkg::CH_MAIN) ? main_dout : video_dout;
    endfunction

    task automatic load_golden();
        int    fd;
        string line;
        string name;
        string op;
        int    ch;
        logic [23:0] a;
        logic [23:0] b;
        logic [23:0] ea;
        logic [15:0] d;
        logic [15:0] ed;
        n_tests = 0;
        fd = $fopen("tb/uma_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden data file tb/uma_golden.txt");
            errors = errors + 1;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#"
                    && $sscanf(line, "%s %d %s %h %h %h %h %h",
                               name, ch, op, a, d, b, ea, ed) == 8) begin
                    t_name[n_tests]     = name;
                    t_ch[n_tests]       = ch;
                    t_op[n_tests]       = op;
                    t_addr[n_tests]     = a;
                    t_wdata[n_tests]    = d;
                    t_base[n_tests]     = b;
                    t_exp_addr[n_tests] = ea;
                    t_exp_data[n_tests] = ed;
                    n_tests             = n_tests + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic start_request(input int i);
        if (t_ch[i] == uma_mem_pkg::CH_MAIN) begin
            base_0    = t_base[i];
            main_addr = t_addr[i];
            main_din  = t_wdata[i];
            case (op_code(t_op[i]))
                OP_RD:   main_oe_n = 1'b0;
                OP_WR:   main_we_n = 1'b0;
                default: main_rfsh_n = 1'b0;
            endcase
        end else begin
            base_1     = t_base[i];
            video_addr = t_addr[i];
            video_din  = t_wdata[i];
            case (op_code(t_op[i]))
                OP_RD:   video_oe_n = 1'b0;
                OP_WR:   video_we_n = 1'b0;
                default: video_rfsh_n = 1'b0;
            endcase
        end
    endtask

    task automatic release_strobes(input int ch);
        if (ch == uma_mem_pkg::CH_MAIN) begin
            main_oe_n   = 1'b1;
            main_we_n   = 1'b1;
            main_rfsh_n = 1'b1;
        end else begin
            video_oe_n   = 1'b1;
            video_we_n   = 1'b1;
            video_rfsh_n = 1'b1;
        end
    endtask

    // Nothing may move on either side while idle
    task automatic check_idle(input int i);
        for (int c = 0; c < int'(t_addr[i]); c++) begin
            @(posedge CLK);
            #1;
            check({t_name[i], " idle"}, 32'h1f,
                  {27'b0, main_ack_n, video_ack_n, pri_oe_n, pri_we_n, pri_rfsh_n});
        end
    endtask

    // One request, or two started on the same cycle
    task automatic run_group(input int first, input int count);
        int busy;
        int cycles;
        int log_start;
        int hits;
        int i;
        log_start = log_count;
        busy      = (count == 2) ? 3 : 1;
        for (int k = 0; k < count; k++) begin
            start_request(first + k);
        end
        @(posedge CLK);
        #1;
        for (int k = 0; k < count; k++) begin
            check({t_name[first + k], " ack"}, 0, 32'(ack_of(t_ch[first + k])));
        end
        cycles = 0;
        while (busy != 0 && cycles < TIMEOUT) begin
            @(posedge CLK);
            #1;
            cycles = cycles + 1;
            for (int k = 0; k < count; k++) begin
                i = first + k;
                if (busy[k] && ack_of(t_ch[i])) begin
                    if (op_code(t_op[i]) == OP_RD) begin
                        check({t_name[i], " dout"}, 32'(t_exp_data[i]),
                              32'(dout_of(t_ch[i])));
                    end
                    release_strobes(t_ch[i]);
                    busy[k] = 1'b0;
                end
            end
        end
        if (busy != 0) begin
            $display("Timeout: %s got no acknowledge within %0d cycles", t_name[first], TIMEOUT);
            errors  = errors + 1;
            aborted = 1'b1;
        end else begin
            // Each request shows up exactly once on the shared port
            for (int k = 0; k < count; k++) begin
                i    = first + k;
                hits = 0;
                for (int j = log_start; j < log_count; j++) begin
                    if (log_op[j] == op_code(t_op[i]) && log_addr[j] == t_exp_addr[i]
                        && (log_op[j] == OP_RD
                            || log_din[j] == ((log_op[j] == OP_WR) ? t_wdata[i] : 16'h0))) begin
                        hits = hits + 1;
                    end
                end
                check({t_name[i], " access"}, 1, hits);
            end
            check({t_name[first], " accesses"}, count, log_count - log_start);
        end
    endtask

    initial begin
        int          idx;
        int          count;
        int          gap;
        int          err_before;
        int          tests_run;
        int          tests_failed;
        void'($urandom(63442));
        RESET_n      = 1'b0;
        base_0       = '0;
        base_1       = '0;
        main_addr    = '0;
        main_din     = '0;
        video_addr   = '0;
        video_din    = '0;
        errors       = 0;
        aborted      = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        release_strobes(uma_mem_pkg::CH_MAIN);
        release_strobes(uma_mem_pkg::CH_VIDEO);
        load_golden();
        repeat (5) @(posedge CLK);
        #1;
        RESET_n = 1'b1;
        idx = 0;
        while (idx < n_tests && !aborted) begin
            gap = 1 + int'($urandom % 12);     // Lands requests on varying slot phases
            repeat (gap) @(posedge CLK);
            #1;
            err_before = errors;
            if (op_code(t_op[idx]) == OP_IDLE) begin
                count = 1;
                check_idle(idx);
            end else begin
                count = (t_op[idx].getc(t_op[idx].len() - 1) == "+" && idx + 1 < n_tests) ? 2 : 1;
                run_group(idx, count);
            end
            for (int k = 0; k < count; k++) begin
                $display("%-10s %s", t_name[idx + k], (errors == err_before) ? "pass" : "FAIL");
            end
            tests_run = tests_run + count;
            if (errors != err_before) begin
                tests_failed = tests_failed + count;
            end
            idx = idx + count;
        end
        errors = errors + onehot_bad;
        $display("Tests run: %0d, failed: %0d, failed checks: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && n_tests > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/uma_client_port.sv
// Client port for one channel: strobe edge detection, pending request
// hold, issue on the channel's execute pulse, read data and ACK_n return

`default_nettype none

module uma_client_port (
    input  wire logic               CLK,
    input  wire logic               RESET_n,
    input  wire logic               exec,
    input  wire logic               slot_done,
    input  wire uma_mem_pkg::addr_t addr,
    input  wire uma_mem_pkg::data_t din,
    input  wire logic               oe_n,
    input  wire logic               we_n,
    input  wire logic               rfsh_n,
    input  wire uma_mem_pkg::data_t pri_dout_q,
    output uma_mem_pkg::data_t      dout,
    output logic                    ack_n,
    output logic                    issue,
    output logic                    req_oe,
    output logic                    req_we,
    output logic                    req_rfsh,
    output uma_mem_pkg::addr_t      req_addr,
    output uma_mem_pkg::data_t      req_din
);

    logic               prev_oe_n;
    logic               prev_we_n;
    logic               prev_rfsh_n;
    logic               det_oe;
    logic               det_we;
    logic               det_rfsh;
    logic               det_any;
    logic               save_oe;        // Pending until the next execute
    logic               save_we;
    logic               save_rfsh;
    logic               req_any;
    logic               processing;     // Issued, waiting for completion
    logic               done;
    uma_mem_pkg::addr_t save_addr;
    uma_mem_pkg::data_t save_din;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            prev_oe_n   <= 1'b1;
            prev_we_n   <= 1'b1;
            prev_rfsh_n <= 1'b1;
        end else begin
            prev_oe_n   <= oe_n;
            prev_we_n   <= we_n;
            prev_rfsh_n <= rfsh_n;
        end
    end

    // High to low on any strobe is a new request
    assign det_oe   = prev_oe_n & ~oe_n;
    assign det_we   = prev_we_n & ~we_n;
    assign det_rfsh = prev_rfsh_n & ~rfsh_n;
    assign det_any  = det_oe | det_we | det_rfsh;

    // Edge cycle goes straight through, later cycles use the latched copy
    assign req_oe   = det_oe | save_oe;
    assign req_we   = det_we | save_we;
    assign req_rfsh = det_rfsh | save_rfsh;
    assign req_any  = req_oe | req_we | req_rfsh;
    assign req_addr = (det_oe | det_we) ? addr : save_addr;
    assign req_din  = det_we ? din : save_din;

    assign issue = exec & req_any;
    assign done  = slot_done & processing;

    // All pending flags go out together on issue
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            save_oe   <= 1'b0;
            save_we   <= 1'b0;
            save_rfsh <= 1'b0;
        end else if (issue) begin
            save_oe   <= 1'b0;
            save_we   <= 1'b0;
            save_rfsh <= 1'b0;
        end else begin
            save_oe   <= save_oe | det_oe;
            save_we   <= save_we | det_we;
            save_rfsh <= save_rfsh | det_rfsh;
        end
    end

    always_ff @(posedge CLK) begin
        if (det_oe | det_we) begin
            save_addr <= addr;
        end
        if (det_we) begin
            save_din <= din;
        end
    end

    // A new issue wins over the completion of the previous one
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            processing <= 1'b0;
        end else if (issue) begin
            processing <= 1'b1;
        end else if (done) begin
            processing <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (done) begin
            dout <= pri_dout_q;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            ack_n <= 1'b1;
        end else if (det_any) begin
            ack_n <= 1'b0;
        end else if (done && !req_any) begin
            ack_n <= 1'b1;                  // Nothing left queued
        end
    end

endmodule

`default_nettype wire

// File: verilog/uma_mem_pkg.sv
// Memory bus widths, payload types and channel numbering
// Shared by the client ports, the mux and the top level

`default_nettype none

package uma_mem_pkg;

    localparam int ADDR_W = 24;         // Byte address space of the shared RAM
    localparam int DATA_W = 16;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Client channels
    localparam int CH_COUNT = 2;
    localparam int CH_MAIN  = 0;        // Main RAM
    localparam int CH_VIDEO = 1;        // Video RAM

endpackage

`default_nettype wire

// File: verilog/uma_primary_mux.sv
// Shared RAM port driver: picks the issuing channel, adds its base
// offset and registers address, data and one-hot strobes

`default_nettype none

module uma_primary_mux (
    input  wire logic               CLK,
    input  wire logic               RESET_n,
    input  wire uma_mem_pkg::addr_t base_0,
    input  wire uma_mem_pkg::addr_t base_1,
    input  wire logic               issue_0,
    input  wire logic               issue_1,
    input  wire logic               req_oe_0,
    input  wire logic               req_we_0,
    input  wire logic               req_rfsh_0,
    input  wire uma_mem_pkg::addr_t req_addr_0,
    input  wire uma_mem_pkg::data_t req_din_0,
    input  wire logic               req_oe_1,
    input  wire logic               req_we_1,
    input  wire logic               req_rfsh_1,
    input  wire uma_mem_pkg::addr_t req_addr_1,
    input  wire uma_mem_pkg::data_t req_din_1,
    input  wire logic               pri_ack_n,
    input  wire uma_mem_pkg::data_t pri_dout,
    output uma_mem_pkg::addr_t      pri_addr,
    output uma_mem_pkg::data_t      pri_din,
    output logic                    pri_oe_n,
    output logic                    pri_we_n,
    output logic                    pri_rfsh_n,
    output uma_mem_pkg::data_t      pri_dout_q
);

    logic [uma_mem_pkg::CH_COUNT-1:0] issue_vec;
    logic [uma_mem_pkg::CH_COUNT-1:0] oe_vec;
    logic [uma_mem_pkg::CH_COUNT-1:0] we_vec;
    logic [uma_mem_pkg::CH_COUNT-1:0] rfsh_vec;
    uma_mem_pkg::addr_t               base [uma_mem_pkg::CH_COUNT];
    uma_mem_pkg::addr_t               addr [uma_mem_pkg::CH_COUNT];
    uma_mem_pkg::data_t               din  [uma_mem_pkg::CH_COUNT];
    int                               sel;
    logic                             load;
    logic                             mem_op;     // Read or write, not refresh

    assign issue_vec = {issue_1, issue_0};
    assign oe_vec    = {req_oe_1, req_oe_0};
    assign we_vec    = {req_we_1, req_we_0};
    assign rfsh_vec  = {req_rfsh_1, req_rfsh_0};

    assign base[uma_mem_pkg::CH_MAIN]  = base_0;
    assign base[uma_mem_pkg::CH_VIDEO] = base_1;
    assign addr[uma_mem_pkg::CH_MAIN]  = req_addr_0;
    assign addr[uma_mem_pkg::CH_VIDEO] = req_addr_1;
    assign din[uma_mem_pkg::CH_MAIN]   = req_din_0;
    assign din[uma_mem_pkg::CH_VIDEO]  = req_din_1;

    // Main channel first if both fire together
    assign sel = issue_vec[uma_mem_pkg::CH_MAIN] ? uma_mem_pkg::CH_MAIN : uma_mem_pkg::CH_VIDEO;

    assign load   = pri_ack_n & (|issue_vec);
    assign mem_op = oe_vec[sel] | we_vec[sel];

    // Strobes drop back as soon as the RAM acknowledges
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            pri_oe_n   <= 1'b1;
            pri_we_n   <= 1'b1;
            pri_rfsh_n <= 1'b1;
        end else if (!pri_ack_n) begin
            pri_oe_n   <= 1'b1;
            pri_we_n   <= 1'b1;
            pri_rfsh_n <= 1'b1;
        end else if (load) begin
            pri_oe_n   <= ~oe_vec[sel];
            pri_we_n   <= ~we_vec[sel];
            pri_rfsh_n <= ~rfsh_vec[sel];
        end
    end

    // Offset add wraps at 24 bits
    always_ff @(posedge CLK) begin
        if (load) begin
            pri_addr <= mem_op ? addr[sel] + base[sel] : '0;
            pri_din  <= mem_op ? din[sel] : '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (!pri_ack_n) begin
            pri_dout_q <= pri_dout;     // Held for the completing port
        end
    end

endmodule

`default_nettype wire

// File: verilog/uma_slot_timer.sv
// Slot timer: counter restarted by CLK_EN, alternating channel slots
// and the delayed execute pulses that drive the client ports

`default_nettype none

module uma_slot_timer (
    input  wire logic CLK,
    input  wire logic RESET_n,
    input  wire logic CLK_EN,
    output logic      exec_0,
    output logic      exec_1,
    output logic      slot_done
);

    logic [uma_timing_pkg::SLOT_CNT_W-1:0] cnt;
    logic                                  slot_hit;
    logic                                  slot_0;
    logic                                  slot_1;
    logic                                  toggle;      // Owner of the next slot
    logic [uma_timing_pkg::EXEC_DELAY-1:0] dly_0;
    logic [uma_timing_pkg::EXEC_DELAY-1:0] dly_1;

    // Restart on every system clock enable, hold at the last count
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            cnt <= '0;
        end else if (CLK_EN) begin
            cnt <= '0;
        end else if (int'(cnt) != uma_timing_pkg::SLOT_DIV - 1) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign slot_hit = (int'(cnt) == uma_timing_pkg::SLOT_OFFSET)
        || (int'(cnt) == uma_timing_pkg::SLOT_OFFSET + uma_timing_pkg::SLOT_SPACING)
        || (int'(cnt) == uma_timing_pkg::SLOT_OFFSET + 2 * uma_timing_pkg::SLOT_SPACING);

    // Slots go main, video, main, ... across period boundaries too
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            slot_0 <= 1'b0;
            slot_1 <= 1'b0;
            toggle <= 1'b0;
        end else if (slot_hit) begin
            slot_0 <= ~toggle;
            slot_1 <= toggle;
            toggle <= ~toggle;
        end else begin
            slot_0 <= 1'b0;
            slot_1 <= 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            dly_0 <= '0;
            dly_1 <= '0;
        end else begin
            dly_0 <= {dly_0[uma_timing_pkg::EXEC_DELAY-2:0], slot_0};
            dly_1 <= {dly_1[uma_timing_pkg::EXEC_DELAY-2:0], slot_1};
        end
    end

    assign exec_0    = dly_0[uma_timing_pkg::EXEC_DELAY-1];
    assign exec_1    = dly_1[uma_timing_pkg::EXEC_DELAY-1];
    assign slot_done = exec_0 | exec_1;     // Any execute ends the running access

endmodule

`default_nettype wire

// File: verilog/uma_timing_pkg.sv
// Slot timing constants for the unified memory arbiter
// One 3.58 MHz period holds three access slots

`default_nettype none

package uma_timing_pkg;

    // Clocks per 3.58 MHz period
    localparam int SLOT_DIV = 30;

    // Width of the slot counter
    localparam int SLOT_CNT_W = $clog2(SLOT_DIV);

    // The counter runs this far ahead of each slot
    localparam int SLOT_OFFSET = 2;

    // Three slots per period, so 2, 12 and 22
    localparam int SLOT_SPACING = SLOT_DIV / 3;

    // Slot pulse to execute pulse
    localparam int EXEC_DELAY = 2;

endpackage

`default_nettype wire

// File: verilog/uma_top.sv
// Unified memory arbiter top level
// Slot timer, main and video client ports, shared RAM port mux

`default_nettype none

module uma_top (
    input  wire logic               CLK,
    input  wire logic               RESET_n,
    input  wire logic               CLK_EN,
    input  wire uma_mem_pkg::addr_t base_0,
    input  wire uma_mem_pkg::addr_t base_1,
    input  wire uma_mem_pkg::addr_t main_addr,
    input  wire uma_mem_pkg::data_t main_din,
    input  wire logic               main_oe_n,
    input  wire logic               main_we_n,
    input  wire logic               main_rfsh_n,
    output uma_mem_pkg::data_t      main_dout,
    output logic                    main_ack_n,
    input  wire uma_mem_pkg::addr_t video_addr,
    input  wire uma_mem_pkg::data_t video_din,
    input  wire logic               video_oe_n,
    input  wire logic               video_we_n,
    input  wire logic               video_rfsh_n,
    output uma_mem_pkg::data_t      video_dout,
    output logic                    video_ack_n,
    output uma_mem_pkg::addr_t      pri_addr,
    output uma_mem_pkg::data_t      pri_din,
    output logic                    pri_oe_n,
    output logic                    pri_we_n,
    output logic                    pri_rfsh_n,
    input  wire logic               pri_ack_n,
    input  wire uma_mem_pkg::data_t pri_dout
);

    logic               exec_0;
    logic               exec_1;
    logic               slot_done;
    logic               main_issue;
    logic               main_req_oe;
    logic               main_req_we;
    logic               main_req_rfsh;
    uma_mem_pkg::addr_t main_req_addr;
    uma_mem_pkg::data_t main_req_din;
    logic               video_issue;
    logic               video_req_oe;
    logic               video_req_we;
    logic               video_req_rfsh;
    uma_mem_pkg::addr_t video_req_addr;
    uma_mem_pkg::data_t video_req_din;
    uma_mem_pkg::data_t pri_dout_q;

    uma_slot_timer u_timer (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .CLK_EN    (CLK_EN),
        .exec_0    (exec_0),
        .exec_1    (exec_1),
        .slot_done (slot_done)
    );

    // Channel 0
    uma_client_port u_main (
        .CLK        (CLK),
        .RESET_n    (RESET_n),
        .exec       (exec_0),
        .slot_done  (slot_done),
        .addr       (main_addr),
        .din        (main_din),
        .oe_n       (main_oe_n),
        .we_n       (main_we_n),
        .rfsh_n     (main_rfsh_n),
        .pri_dout_q (pri_dout_q),
        .dout       (main_dout),
        .ack_n      (main_ack_n),
        .issue      (main_issue),
        .req_oe     (main_req_oe),
        .req_we     (main_req_we),
        .req_rfsh   (main_req_rfsh),
        .req_addr   (main_req_addr),
        .req_din    (main_req_din)
    );

    // Channel 1
    uma_client_port u_video (
        .CLK        (CLK),
        .RESET_n    (RESET_n),
        .exec       (exec_1),
        .slot_done  (slot_done),
        .addr       (video_addr),
        .din        (video_din),
        .oe_n       (video_oe_n),
        .we_n       (video_we_n),
        .rfsh_n     (video_rfsh_n),
        .pri_dout_q (pri_dout_q),
        .dout       (video_dout),
        .ack_n      (video_ack_n),
        .issue      (video_issue),
        .req_oe     (video_req_oe),
        .req_we     (video_req_we),
        .req_rfsh   (video_req_rfsh),
        .req_addr   (video_req_addr),
        .req_din    (video_req_din)
    );

    uma_primary_mux u_mux (
        .CLK        (CLK),
        .RESET_n    (RESET_n),
        .base_0     (base_0),
        .base_1     (base_1),
        .issue_0    (main_issue),
        .issue_1    (video_issue),
        .req_oe_0   (main_req_oe),
        .req_we_0   (main_req_we),
        .req_rfsh_0 (main_req_rfsh),
        .req_addr_0 (main_req_addr),
        .req_din_0  (main_req_din),
        .req_oe_1   (video_req_oe),
        .req_we_1   (video_req_we),
        .req_rfsh_1 (video_req_rfsh),
        .req_addr_1 (video_req_addr),
        .req_din_1  (video_req_din),
        .pri_ack_n  (pri_ack_n),
        .pri_dout   (pri_dout),
        .pri_addr   (pri_addr),
        .pri_din    (pri_din),
        .pri_oe_n   (pri_oe_n),
        .pri_we_n   (pri_we_n),
        .pri_rfsh_n (pri_rfsh_n),
        .pri_dout_q (pri_dout_q)
    );

endmodule

`default_nettype wire
